/* sources.f */
+incdir+.
lcd_pkg.sv
lcd_text_if.sv
lcd_axil_regs.sv
lcd1602_ctrl.sv
lcd_top.sv
lcd_bus_monitor.sv
tb_lcd_top.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lcd_top -f sources.f --Mdir obj_dir -o sim

./obj_dir/sim 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* tb_lcd_top.sv */
`timescale 1ns/1ps
`include "lcd_settings.svh"

module tb_lcd_top;
    localparam int AW = `LCD_AXI_AW;
    localparam int AXI_TIMEOUT = 50;
    localparam int BYTE_TIMEOUT = (`LCD_INIT_PERIODS + 2) * `LCD_CLK_DIV;
    localparam int HOLD_CYCLES = 6;
    localparam logic [AW-1:0] STATUS = AW'(`LCD_STATUS_ADDR);
    localparam logic [AW-1:0] UNMAPPED = AW'('h30);

    logic clk;
    logic nrst;
    logic [AW-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [AW-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic lcd_en;
    logic lcd_rw;
    logic lcd_rs;
    logic [7:0] lcd_data;
    logic cap_valid;
    logic [7:0] cap_byte;
    logic cap_rs;
    logic [31:0] rng;
    logic [31:0] model [8];     // Expected text words

    always #20 clk = ~clk;

    lcd_top i_dut (.*);

    lcd_bus_monitor i_mon (
        .clk, .nrst, .lcd_en, .lcd_rs, .lcd_data,
        .cap_valid, .cap_byte, .cap_rs
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [AW-1:0] text_addr(input int word);
        if (word < 4) begin
            return AW'(`LCD_ROW1_BASE + 4 * word);
        end
        return AW'(`LCD_ROW2_BASE + 4 * (word - 4));
    endfunction

    // Column 0 is the top byte of the row's first word
    function automatic logic [7:0] expected_char(input int row, input int col);
        logic [31:0] w;
        w = model[row * 4 + col / 4];
        return w[8 * (3 - col % 4) +: 8];
    endfunction

    // Returns on the falling edge after the response becomes valid
    task automatic write_request(input logic [AW-1:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb);
        int n;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > AXI_TIMEOUT) fail_timeout("bvalid");
        end while (!bvalid);
        awvalid = 1'b0;
        wvalid = 1'b0;
    endtask

    task automatic read_request(input logic [AW-1:0] addr);
        int n;
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > AXI_TIMEOUT) fail_timeout("rvalid");
        end while (!rvalid);
        arvalid = 1'b0;
    endtask

    task automatic axi_write(input logic [AW-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        bready = 1'b1;
        write_request(addr, data, strb);
        resp = bresp;
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [AW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        rready = 1'b1;
        read_request(addr);
        data = rdata;
        resp = rresp;
        @(negedge clk);
    endtask

    task automatic wait_capture(output logic [7:0] b, output logic rs);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > BYTE_TIMEOUT) fail_timeout("an LCD byte");
        end while (!cap_valid);
        b = cap_byte;
        rs = cap_rs;
    endtask

    task automatic expect_byte(input logic [7:0] exp_byte, input logic exp_rs);
        logic [7:0] b;
        logic rs;
        wait_capture(b, rs);
        check("lcd_data", 32'(b), 32'(exp_byte));
        check("lcd_rs", 32'(rs), 32'(exp_rs));
    endtask

    task automatic wait_row1_addr();
        logic [7:0] b;
        logic rs;
        int n;
        n = 0;
        do begin
            wait_capture(b, rs);
            n++;
            if (n > 40) fail_timeout("the row 1 address command");
        end while (b != 8'h80 || rs);
    endtask

    task automatic verify_text();
        logic [31:0] d;
        logic [1:0] resp;
        for (int i = 0; i < 8; i++) begin
            axi_read(text_addr(i), d, resp);
            check("rdata", d, model[i]);
            check("rresp", 32'(resp), 32'h0);
        end
    endtask

    task automatic reset_state_test();
        logic [31:0] d;
        logic [1:0] resp;
        check("lcd_data", 32'(lcd_data), 32'h0);
        check("lcd_rs", 32'(lcd_rs), 32'h0);
        check("lcd_rw", 32'(lcd_rw), 32'h0);
        check("lcd_en", 32'(lcd_en), 32'h1);
        check("bvalid", 32'(bvalid), 32'h0);
        check("rvalid", 32'(rvalid), 32'h0);
        axi_read(STATUS, d, resp);
        check("status", d, 32'h0);
        check("rresp", 32'(resp), 32'h0);
    endtask

    task automatic init_sequence_test();
        logic [7:0] init_seq [6] = '{8'h38, 8'h08, 8'h01, 8'h06, 8'h0C, 8'h80};
        logic [31:0] d;
        logic [1:0] resp;
        for (int i = 0; i < 6; i++) begin
            expect_byte(init_seq[i], 1'b0);
        end
        axi_read(STATUS, d, resp);
        check("status", d, 32'h1);  // No frame finished yet
    endtask

    task automatic readback_test();
        logic [31:0] d;
        logic [3:0] strb;
        logic [1:0] resp;
        for (int i = 0; i < 8; i++) begin
            d = next_rand();
            model[i] = d;
            axi_write(text_addr(i), d, 4'hF, resp);
            check("bresp", 32'(resp), 32'h0);
        end
        for (int i = 0; i < 8; i++) begin
            d = next_rand();
            strb = 4'(next_rand() >> 28);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model[i][8 * b +: 8] = d[8 * b +: 8];
            end
            axi_write(text_addr(i), d, strb, resp);
            check("bresp", 32'(resp), 32'h0);
        end
        verify_text();
    endtask

    task automatic unmapped_test();
        logic [31:0] d;
        logic [1:0] resp;
        axi_write(UNMAPPED, next_rand(), 4'hF, resp);
        check("bresp", 32'(resp), 32'h2);
        axi_read(UNMAPPED, d, resp);
        check("rdata", d, 32'h0);
        check("rresp", 32'(resp), 32'h2);
        verify_text();
    endtask

    task automatic frame_content_test();
        wait_row1_addr();
        for (int c = 0; c < 16; c++) begin
            expect_byte(expected_char(0, c), 1'b1);
        end
        expect_byte(8'hC0, 1'b0);
        for (int c = 0; c < 16; c++) begin
            expect_byte(expected_char(1, c), 1'b1);
        end
    endtask

    task automatic frame_count_test();
        logic [31:0] s0;
        logic [31:0] s1;
        logic [1:0] resp;
        logic [15:0] delta;
        logic [7:0] b;
        logic rs;
        int row1_seen;
        int n;
        wait_row1_addr();
        axi_read(STATUS, s0, resp);
        row1_seen = 1;
        n = 0;
        while (row1_seen < 3) begin
            wait_capture(b, rs);
            if (b == 8'h80 && !rs) row1_seen++;
            n++;
            if (n > 80) fail_timeout("two more frames");
        end
        axi_read(STATUS, s1, resp);
        delta = s1[31:16] - s0[31:16];
        check("frame count delta", 32'(delta), 32'(row1_seen - 1));
    endtask

    task automatic backpressure_test();
        rready = 1'b0;
        read_request(text_addr(2));
        arvalid = 1'b1;             // Second read must wait
        araddr = STATUS;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check("rvalid", 32'(rvalid), 32'h1);
            check("rdata", rdata, model[2]);
            check("arready", 32'(arready), 32'h0);
        end
        arvalid = 1'b0;
        rready = 1'b1;
        @(negedge clk);
        check("rvalid", 32'(rvalid), 32'h0);
        check("arready", 32'(arready), 32'h1);
        bready = 1'b0;
        write_request(text_addr(5), model[5], 4'hF);
        wdata = ~model[5];          // Would corrupt word 5 if accepted
        awvalid = 1'b1;
        wvalid = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check("bvalid", 32'(bvalid), 32'h1);
            check("bresp", 32'(bresp), 32'h0);
            check("awready", 32'(awready), 32'h0);
            check("wready", 32'(wready), 32'h0);
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        @(negedge clk);
        check("bvalid", 32'(bvalid), 32'h0);
        verify_text();
    endtask

    initial begin
        clk = 1'b0;
        nrst = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = 32'h0;
        wstrb = 4'h0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rng = 32'h5a7d_dd35;
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        reset_state_test();
        init_sequence_test();
        readback_test();
        unmapped_test();
        frame_content_test();
        frame_count_test();
        backpressure_test();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* lcd_bus_monitor.sv */
`timescale 1ns/1ps

module lcd_bus_monitor (
    input  logic clk,
    input  logic nrst,
    input  logic lcd_en,
    input  logic lcd_rs,
    input  logic [7:0] lcd_data,
    output logic cap_valid,     // One cycle per captured byte
    output logic [7:0] cap_byte,
    output logic cap_rs
);
    logic en_q;
    logic en_fall;

    assign en_fall = en_q && !lcd_en;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            en_q <= 1'b1;
            cap_valid <= 1'b0;
            cap_byte <= 8'h00;
            cap_rs <= 1'b0;
        end else begin
            en_q <= lcd_en;
            cap_valid <= en_fall;
            if (en_fall) begin
                cap_byte <= lcd_data;   // Bus is stable across the enable fall
                cap_rs <= lcd_rs;
            end
        end
    end

endmodule

/* lcd_top.sv */
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_top (
    input  logic clk,
    input  logic nrst,

    input  logic [`LCD_AXI_AW-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,

    input  logic [`LCD_AXI_AW-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,

    output logic lcd_en,
    output logic lcd_rw,
    output logic lcd_rs,
    output logic [7:0] lcd_data
);
    lcd_text_if i_text ();

    lcd_axil_regs i_regs (
        .clk, .nrst,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .text (i_text.regs)
    );

    lcd1602_ctrl #(.clk_div(`LCD_CLK_DIV)) i_ctrl (
        .clk, .nrst,
        .text (i_text.ctrl),
        .lcd_en, .lcd_rw, .lcd_rs, .lcd_data
    );

endmodule

/* lcd1602_ctrl.sv */
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd1602_ctrl #(
    parameter int clk_div = 20_000
) (
    input  logic clk,
    input  logic nrst,

    lcd_text_if.ctrl text,

    output logic lcd_en,
    output logic lcd_rw,
    output logic lcd_rs,
    output logic [7:0] lcd_data
);
    localparam int INIT_CYCLES = `LCD_INIT_PERIODS * clk_div;
    localparam int PON_W = $clog2(INIT_CYCLES);
    localparam int PER_W = $clog2(clk_div + 1);
    localparam logic [PON_W-1:0] PON_LAST = PON_W'(INIT_CYCLES - 1);
    localparam logic [PER_W-1:0] PER_LAST = PER_W'(clk_div - 1);
    localparam logic [PER_W-1:0] EN_LAST = PER_W'((clk_div - 1) / 2);

    // Step numbering, 0 is idle after reset
    localparam logic [5:0] STEP_SET_FUNC = 6'd1;
    localparam logic [5:0] STEP_DISP_OFF = 6'd2;
    localparam logic [5:0] STEP_CLEAR = 6'd3;
    localparam logic [5:0] STEP_ENTRY = 6'd4;
    localparam logic [5:0] STEP_DISP_ON = 6'd5;
    localparam logic [5:0] STEP_ROW1_ADDR = 6'd6;
    localparam logic [5:0] STEP_ROW1_0 = 6'd7;
    localparam logic [5:0] STEP_ROW2_ADDR = 6'd23;
    localparam logic [5:0] STEP_ROW2_0 = 6'd24;
    localparam logic [5:0] STEP_LAST = 6'd39;

    logic [PON_W-1:0] pon_cnt;
    logic pon_done;
    logic [PER_W-1:0] per_cnt;
    logic step_stb;

    logic [5:0] step;
    logic [5:0] next_step;
    logic in_row2;
    logic [3:0] col;
    logic [7:0] step_byte;
    logic step_rs;

    assign pon_done = pon_cnt == PON_LAST;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pon_cnt <= '0;
        end else if (!pon_done) begin
            pon_cnt <= pon_cnt + 1'b1;
        end
    end

    // Free running, so the last wait cycle is also a period boundary
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            per_cnt <= '0;
        end else if (per_cnt == PER_LAST) begin
            per_cnt <= '0;
        end else begin
            per_cnt <= per_cnt + 1'b1;
        end
    end

    // High through the power-on wait and in first half of each period
    assign lcd_en = (step == 6'd0) || (per_cnt <= EN_LAST);
    assign step_stb = pon_done && (per_cnt == PER_LAST);
    assign lcd_rw = 1'b0;

    // Frame loops back to the row 1 address
    assign next_step = (step == STEP_LAST) ? STEP_ROW1_ADDR : step + 6'd1;

    assign in_row2 = next_step >= STEP_ROW2_0;
    assign col = 4'(next_step - (in_row2 ? STEP_ROW2_0 : STEP_ROW1_0));
    assign text.char_idx = {in_row2, col};

    always_comb begin
        step_byte = 8'h00;
        step_rs = 1'b0;
        case (next_step)
            STEP_SET_FUNC:  step_byte = 8'h38;   // 8-bit bus, 2 lines, 5x8 font
            STEP_DISP_OFF:  step_byte = 8'h08;
            STEP_CLEAR:     step_byte = 8'h01;
            STEP_ENTRY:     step_byte = 8'h06;   // Increment, no shift
            STEP_DISP_ON:   step_byte = 8'h0C;   // Display on, cursor off
            STEP_ROW1_ADDR: step_byte = 8'h80;
            STEP_ROW2_ADDR: step_byte = 8'hC0;
            default: begin
                step_byte = text.char_data;
                step_rs = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step <= '0;
            lcd_data <= 8'h00;
            lcd_rs <= 1'b0;
        end else if (step_stb) begin
            step <= next_step;
            lcd_data <= step_byte;
            lcd_rs <= step_rs;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            text.frame_done <= 1'b0;
            text.init_done <= 1'b0;
        end else begin
            text.frame_done <= step_stb && (next_step == STEP_LAST);
            if (step_stb && (next_step == STEP_DISP_ON)) begin
                text.init_done <= 1'b1;      // Stays set
            end
        end
    end

endmodule

/* lcd_axil_regs.sv */
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_axil_regs
    import lcd_pkg::*;
(
    input  logic clk,
    input  logic nrst,

    input  logic [`LCD_AXI_AW-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,

    input  logic [`LCD_AXI_AW-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,

    lcd_text_if.regs text
);
    localparam int AW = `LCD_AXI_AW;
    localparam logic [AW-1:0] ROW1_BASE = AW'(`LCD_ROW1_BASE);
    localparam logic [AW-1:0] ROW2_BASE = AW'(`LCD_ROW2_BASE);
    localparam logic [AW-1:0] STATUS_ADDR = AW'(`LCD_STATUS_ADDR);
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    char_word_u text_q [8];     // Words 0-3 row 1, 4-7 row 2
    char_word_u status_w;
    logic [15:0] frame_cnt;

    logic wr_hs;
    logic wr_row1;
    logic wr_row2;
    logic wr_status;
    logic [2:0] wr_idx;

    logic rd_hs;
    logic rd_row1;
    logic rd_row2;
    logic rd_status;
    logic [2:0] rd_idx;
    logic [31:0] rd_word;
    logic [1:0] rd_resp;

    // Rows are 16-byte aligned, status is one word
    assign wr_row1 = awaddr[AW-1:4] == ROW1_BASE[AW-1:4];
    assign wr_row2 = awaddr[AW-1:4] == ROW2_BASE[AW-1:4];
    assign wr_status = awaddr[AW-1:2] == STATUS_ADDR[AW-1:2];
    assign wr_idx = {wr_row2, awaddr[3:2]};

    assign rd_row1 = araddr[AW-1:4] == ROW1_BASE[AW-1:4];
    assign rd_row2 = araddr[AW-1:4] == ROW2_BASE[AW-1:4];
    assign rd_status = araddr[AW-1:2] == STATUS_ADDR[AW-1:2];
    assign rd_idx = {rd_row2, araddr[3:2]};

    // Address and data taken together
    assign wr_hs = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready = wr_hs;

    always_ff @(posedge clk) begin
        if (wr_hs && (wr_row1 || wr_row2)) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    text_q[wr_idx].raw[8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= (wr_row1 || wr_row2 || wr_status) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign status_w.raw = {frame_cnt, 15'd0, text.init_done};

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        if (rd_row1 || rd_row2) begin
            rd_word = text_q[rd_idx].raw;
        end else if (rd_status) begin
            rd_word = status_w.raw;
        end else begin
            rd_resp = RESP_SLVERR;   // Unmapped reads as zero
        end
    end

    assign arready = !rvalid;
    assign rd_hs = arvalid && arready;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            frame_cnt <= '0;
        end else if (text.frame_done) begin
            frame_cnt <= frame_cnt + 16'd1;  // Wraps
        end
    end

    // Column 0 sits in the top byte of each word
    assign text.char_data = text_q[text.char_idx[4:2]].chars[~text.char_idx[1:0]];

endmodule

/* lcd_text_if.sv */
`timescale 1ns/1ps

interface lcd_text_if;
    logic [4:0] char_idx;   // Bit 4 row, bits 3:0 column
    logic [7:0] char_data;
    logic frame_done;       // One cycle after last row 2 char
    logic init_done;

    modport ctrl (
        output char_idx,
        output frame_done,
        output init_done,
        input  char_data
    );

    modport regs (
        input  char_idx,
        input  frame_done,
        input  init_done,
        output char_data
    );
endinterface

/* lcd_pkg.sv */
package lcd_pkg;

    // One bus word, either whole or as four characters
    // chars[3] is the MSB and the leftmost character on screen
    typedef union packed {
        logic [31:0] raw;
        logic [3:0][7:0] chars;
    } char_word_u;

endpackage

/* lcd_settings.svh */
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// Clock cycles per LCD enable period
`define LCD_CLK_DIV 20000

// Enable periods spent waiting after power-on
`define LCD_INIT_PERIODS 10

`define LCD_AXI_AW 6

// Byte offsets, each text row is four words
`define LCD_ROW1_BASE 'h00
`define LCD_ROW2_BASE 'h10
`define LCD_STATUS_ADDR 'h20

`endif
